//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 1 << REG_ADDR_W;
    localparam int HALF_W     = WORD_W / 2;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t REG_ZERO = '0;

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_ADDIU   = 6'b001001;
    localparam logic [5:0] OPC_ANDI    = 6'b001100;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_XORI    = 6'b001110;
    localparam logic [5:0] OPC_LUI     = 6'b001111;

    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;

    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_AND = 3'd1,
        OP_OR  = 3'd2,
        OP_XOR = 3'd3,
        OP_ADD = 3'd4,
        OP_SUB = 3'd5,
        OP_LUI = 3'd6
    } oper_e;

    typedef struct packed {
        oper_e     oper;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        logic      wreg_write;
        reg_addr_t wreg_addr;
        word_t     imm;         // Already zero or sign extended.
    } dec_ctrl_t;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        oper_e     oper;
        word_t     reg1;
        word_t     reg2;
        logic      wreg_write;
        reg_addr_t wreg_addr;
    } issue_t;

    localparam issue_t ISSUE_BUBBLE = '{
        oper:       OP_NOP,
        reg1:       '0,
        reg2:       '0,
        wreg_write: 1'b0,
        wreg_addr:  '0
    };

endpackage

`default_nettype wire

//--- decode/inst_decoder.sv
`default_nettype none

module inst_decoder import cpu_pkg::*; (
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    reg_addr_t         rs;
    reg_addr_t         rt;
    reg_addr_t         rd;
    logic [HALF_W-1:0] imm16;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    always_comb begin
        // Read addresses always follow the rs and rt fields, so the register
        // file can be read without waiting for the decode result.
        ctrl_o.oper       = OP_NOP;
        ctrl_o.reg1_read  = 1'b0;
        ctrl_o.reg2_read  = 1'b0;
        ctrl_o.reg1_addr  = rs;
        ctrl_o.reg2_addr  = rt;
        ctrl_o.wreg_write = 1'b0;
        ctrl_o.wreg_addr  = REG_ZERO;
        ctrl_o.imm        = '0;

        case (opcode)
            OPC_SPECIAL: begin
                ctrl_o.reg1_read  = 1'b1;
                ctrl_o.reg2_read  = 1'b1;
                ctrl_o.wreg_write = 1'b1;
                ctrl_o.wreg_addr  = rd;
                case (funct)
                    FN_AND:  ctrl_o.oper = OP_AND;
                    FN_OR:   ctrl_o.oper = OP_OR;
                    FN_XOR:  ctrl_o.oper = OP_XOR;
                    FN_ADDU: ctrl_o.oper = OP_ADD;
                    FN_SUBU: ctrl_o.oper = OP_SUB;
                    default: begin
                        ctrl_o.reg1_read  = 1'b0;  // Unknown function is a NOP.
                        ctrl_o.reg2_read  = 1'b0;
                        ctrl_o.wreg_write = 1'b0;
                        ctrl_o.wreg_addr  = REG_ZERO;
                    end
                endcase
            end
            OPC_ANDI, OPC_ORI, OPC_XORI: begin
                ctrl_o.reg1_read  = 1'b1;
                ctrl_o.wreg_write = 1'b1;
                ctrl_o.wreg_addr  = rt;
                ctrl_o.imm        = {{HALF_W{1'b0}}, imm16};
                case (opcode)
                    OPC_ANDI: ctrl_o.oper = OP_AND;
                    OPC_ORI:  ctrl_o.oper = OP_OR;
                    default:  ctrl_o.oper = OP_XOR;
                endcase
            end
            OPC_ADDIU: begin
                ctrl_o.oper       = OP_ADD;
                ctrl_o.reg1_read  = 1'b1;
                ctrl_o.wreg_write = 1'b1;
                ctrl_o.wreg_addr  = rt;
                ctrl_o.imm        = {{HALF_W{imm16[HALF_W-1]}}, imm16};  // Sign extended.
            end
            OPC_LUI: begin
                ctrl_o.oper       = OP_LUI;
                ctrl_o.wreg_write = 1'b1;
                ctrl_o.wreg_addr  = rt;
                ctrl_o.imm        = {imm16, {HALF_W{1'b0}}};
            end
            default: begin
                ctrl_o.oper = OP_NOP;
            end
        endcase

        if (ctrl_o.wreg_addr == REG_ZERO) begin
            ctrl_o.wreg_write = 1'b0;  // Writes to r0 are dropped here.
        end
    end

endmodule

`default_nettype wire

//--- decode/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    input  fwd_t      wb_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [REG_NUM];

    // Read with r0 forced to zero and the write-back value bypassed.
    function automatic word_t read_port(
        input reg_addr_t addr,
        input word_t     stored,
        input fwd_t      wb
    );
        word_t result;
        if (addr == REG_ZERO) begin
            result = '0;
        end else if (wb.write && wb.addr == addr) begin
            result = wb.data;
        end else begin
            result = stored;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.write && wb_i.addr != REG_ZERO) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i, regs[raddr1_i], wb_i);
        rdata2_o = read_port(raddr2_i, regs[raddr2_i], wb_i);
    end

endmodule

`default_nettype wire

//--- decode/operand_issue.sv
`default_nettype none

module operand_issue import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      valid_i,
    input  dec_ctrl_t ctrl_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output logic      valid_o,
    output issue_t    issue_o
);

    word_t  reg2_alt;
    issue_t issue_d;

    // EX is the younger result, so it takes precedence over MEM.
    function automatic word_t pick_operand(
        input logic      rd_en,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     alt,
        input fwd_t      ex,
        input fwd_t      mem
    );
        word_t result;
        if (!rd_en) begin
            result = alt;
        end else if (addr == REG_ZERO) begin
            result = '0;  // r0 stays zero even if a forward claims it.
        end else if (ex.write && ex.addr == addr) begin
            result = ex.data;
        end else if (mem.write && mem.addr == addr) begin
            result = mem.data;
        end else begin
            result = rf_data;
        end
        return result;
    endfunction

    assign reg2_alt = (ctrl_i.oper == OP_LUI) ? '0 : ctrl_i.imm;  // LUI has no second operand.

    always_comb begin
        if (valid_i) begin
            issue_d.oper       = ctrl_i.oper;
            issue_d.reg1       = pick_operand(ctrl_i.reg1_read, ctrl_i.reg1_addr, rdata1_i,
                                              ctrl_i.imm, ex_fwd_i, mem_fwd_i);
            issue_d.reg2       = pick_operand(ctrl_i.reg2_read, ctrl_i.reg2_addr, rdata2_i,
                                              reg2_alt, ex_fwd_i, mem_fwd_i);
            issue_d.wreg_write = ctrl_i.wreg_write;
            issue_d.wreg_addr  = ctrl_i.wreg_addr;
        end else begin
            issue_d = ISSUE_BUBBLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o <= 1'b0;
            issue_o <= ISSUE_BUBBLE;
        end else begin
            valid_o <= valid_i;
            issue_o <= issue_d;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_stage.sv
`default_nettype none

module decode_stage import cpu_pkg::*; (
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   valid_i,
    input  word_t  inst_i,
    input  fwd_t   ex_fwd_i,
    input  fwd_t   mem_fwd_i,
    input  fwd_t   wb_i,
    output logic   valid_o,
    output issue_t issue_o
);

    dec_ctrl_t ctrl;
    word_t     rdata1;
    word_t     rdata2;

    inst_decoder u_inst_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    // Register reads come straight from the rs and rt fields, in parallel with decode.
    reg_file u_reg_file (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .raddr1_i (inst_i[25:21]),
        .raddr2_i (inst_i[20:16]),
        .wb_i     (wb_i),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    operand_issue u_operand_issue (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .ctrl_i    (ctrl),
        .rdata1_i  (rdata1),
        .rdata2_i  (rdata2),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .valid_o   (valid_o),
        .issue_o   (issue_o)
    );

endmodule

`default_nettype wire

//--- verif/decode_stage_props.sv
`default_nettype none

module decode_stage_props import cpu_pkg::*; (
    input logic   clk,
    input logic   arst_n_i,
    input logic   valid_o,
    input issue_t issue_o
);

    timeunit 1ns;
    timeprecision 1ps;

    write_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n_i) issue_o.wreg_write |-> valid_o
    ) else $error("wreg_write is set in the issue register while valid_o is low");

    no_write_to_r0: assert property (
        @(posedge clk) disable iff (!arst_n_i) issue_o.wreg_write |-> (issue_o.wreg_addr != '0)
    ) else $error("the issue register writes register 0");

    // The first edge after release still shows the reset value.
    idle_after_reset: assert property (
        @(posedge clk) $rose(arst_n_i) |-> !valid_o
    ) else $error("valid_o is high in the cycle after reset release");

endmodule

bind operand_issue decode_stage_props u_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_o  (valid_o),
    .issue_o  (issue_o)
);

`default_nettype wire

//--- verif/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int   CLK_PERIOD    = 20;
    localparam int   RESET_CYCLES  = 2;
    localparam int   DIR_CYCLES    = 60;
    localparam int   RAND_CYCLES   = 2000;
    localparam int   TOTAL_CYCLES  = RESET_CYCLES + 31 + 5 * DIR_CYCLES + RAND_CYCLES + 6 * 2;
    localparam int   MARGIN_CYCLES = 200;
    localparam fwd_t FWD_IDLE      = '{write: 1'b0, addr: '0, data: '0};

    logic   clk;
    logic   arst_n_i;
    logic   valid_i;
    word_t  inst_i;
    fwd_t   ex_fwd_i;
    fwd_t   mem_fwd_i;
    fwd_t   wb_i;
    logic   valid_o;
    issue_t issue_o;

    word_t       shadow [REG_NUM];  // Mirror of the register file contents.
    issue_t      exp_issue_q [$];
    logic        exp_valid_q [$];
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          tests_run;
    int          tests_failed;

    decode_stage dut (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .inst_i    (inst_i),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .wb_i      (wb_i),
        .valid_o   (valid_o),
        .issue_o   (issue_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic reg_addr_t rand_addr();
        return reg_addr_t'(rand_bits(5));
    endfunction

    function automatic reg_addr_t nonzero_addr();
        reg_addr_t a;
        a = rand_addr();
        return (a == '0) ? reg_addr_t'(1) : a;
    endfunction

    // Half of the picks land on rs or rt of the instruction.
    function automatic reg_addr_t collide_addr(input word_t inst);
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        if (sel == 2'd0) begin
            return inst[25:21];
        end else if (sel == 2'd1) begin
            return inst[20:16];
        end
        return rand_addr();
    endfunction

    function automatic fwd_t rand_fwd(input word_t inst);
        fwd_t f;
        f.write = 1'(rand_bits(1));
        f.addr  = collide_addr(inst);
        f.data  = rand_bits(32);
        return f;
    endfunction

    function automatic word_t r_inst(input int i, input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd);
        logic [5:0] fn;
        case (i % 5)
            0: fn = FN_AND;
            1: fn = FN_OR;
            2: fn = FN_XOR;
            3: fn = FN_ADDU;
            default: fn = FN_SUBU;
        endcase
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_inst(input int i, input reg_addr_t rs, input reg_addr_t rt,
                                     input logic [15:0] imm);
        logic [5:0] opc;
        case (i % 5)
            0: opc = OPC_ANDI;
            1: opc = OPC_ORI;
            2: opc = OPC_XORI;
            3: opc = OPC_ADDIU;
            default: opc = OPC_LUI;
        endcase
        return {opc, rs, rt, imm};
    endfunction

    function automatic word_t random_inst();
        logic [2:0] sel;
        int         k;
        sel = 3'(rand_bits(3));
        k = int'(rand_bits(3));
        case (sel)
            3'd0, 3'd1, 3'd2: return r_inst(k, rand_addr(), rand_addr(), rand_addr());
            3'd3, 3'd4, 3'd5: return i_inst(k, rand_addr(), rand_addr(), 16'(rand_bits(16)));
            3'd6: return {OPC_SPECIAL, 20'(rand_bits(20)), 6'(rand_bits(6))};
            default: return rand_bits(32);
        endcase
    endfunction

    // Forwarding priority is EX, then MEM, then the write-back bypass.
    function automatic word_t model_operand(input logic rd_en, input reg_addr_t a,
                                            input word_t alt, input fwd_t ex, input fwd_t mem,
                                            input fwd_t wb);
        if (!rd_en) return alt;
        if (a == '0) return '0;
        if (ex.write && ex.addr == a) return ex.data;
        if (mem.write && mem.addr == a) return mem.data;
        if (wb.write && wb.addr == a) return wb.data;
        return shadow[a];
    endfunction

    function automatic issue_t model_issue(input logic v, input word_t inst, input fwd_t ex,
                                           input fwd_t mem, input fwd_t wb);
        issue_t    e;
        oper_e     op;
        logic      r1;
        logic      r2;
        logic      known;
        reg_addr_t dest;
        word_t     imm;
        e = '{oper: OP_NOP, reg1: '0, reg2: '0, wreg_write: 1'b0, wreg_addr: '0};
        if (!v) return e;
        op = OP_NOP;
        r1 = 1'b1;
        r2 = 1'b0;
        known = 1'b1;
        dest = inst[20:16];
        imm = {16'h0, inst[15:0]};
        case (inst[31:26])
            OPC_SPECIAL: begin
                r2 = 1'b1;
                dest = inst[15:11];
                imm = '0;
                case (inst[5:0])
                    FN_AND:  op = OP_AND;
                    FN_OR:   op = OP_OR;
                    FN_XOR:  op = OP_XOR;
                    FN_ADDU: op = OP_ADD;
                    FN_SUBU: op = OP_SUB;
                    default: known = 1'b0;
                endcase
            end
            OPC_ANDI:  op = OP_AND;
            OPC_ORI:   op = OP_OR;
            OPC_XORI:  op = OP_XOR;
            OPC_ADDIU: begin
                op = OP_ADD;
                imm = {{16{inst[15]}}, inst[15:0]};
            end
            OPC_LUI: begin
                op = OP_LUI;
                r1 = 1'b0;
                imm = {inst[15:0], 16'h0};
            end
            default: known = 1'b0;
        endcase
        if (!known) begin
            op = OP_NOP;
            r1 = 1'b0;
            r2 = 1'b0;
            imm = '0;
        end
        e.oper = op;
        e.reg1 = model_operand(r1, inst[25:21], imm, ex, mem, wb);
        e.reg2 = model_operand(r2, inst[20:16], (op == OP_LUI) ? '0 : imm, ex, mem, wb);
        e.wreg_write = known && (dest != '0);
        e.wreg_addr = e.wreg_write ? dest : '0;
        return e;
    endfunction

    task automatic report_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_issue(input issue_t got, input issue_t exp);
        checks++;
        report_field("issue_o.oper", 32'(got.oper), 32'(exp.oper));
        report_field("issue_o.reg1", got.reg1, exp.reg1);
        report_field("issue_o.reg2", got.reg2, exp.reg2);
        report_field("issue_o.wreg_write", 32'(got.wreg_write), 32'(exp.wreg_write));
        report_field("issue_o.wreg_addr", 32'(got.wreg_addr), 32'(exp.wreg_addr));
    endtask

    task automatic check_valid(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] valid_o got %h expected %h at %0t ns", got, exp, $time);
        end
    endtask

    task automatic compare_front();
        check_valid(valid_o, exp_valid_q.pop_front());
        check_issue(issue_o, exp_issue_q.pop_front());
    endtask

    // Outputs lag the inputs by one edge, so each call checks the previous one.
    task automatic step(input logic v, input word_t inst, input fwd_t ex, input fwd_t mem,
                        input fwd_t wb);
        @(posedge clk);
        valid_i   <= v;
        inst_i    <= inst;
        ex_fwd_i  <= ex;
        mem_fwd_i <= mem;
        wb_i      <= wb;
        exp_issue_q.push_back(model_issue(v, inst, ex, mem, wb));
        exp_valid_q.push_back(v);
        if (wb.write && wb.addr != '0) shadow[wb.addr] = wb.data;
        @(negedge clk);
        if (exp_issue_q.size() > 1) compare_front();
    endtask

    task automatic drain();
        @(posedge clk);
        valid_i   <= 1'b0;
        ex_fwd_i  <= FWD_IDLE;
        mem_fwd_i <= FWD_IDLE;
        wb_i      <= FWD_IDLE;
        @(negedge clk);
        compare_front();
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("[TEST] %s: ok", name);
        end else begin
            tests_failed++;
            $display("[TEST] %s: %0d mismatches", name, errors - err_before);
        end
    endtask

    task automatic test_bubbles();
        int    e0;
        word_t inst;
        e0 = errors;
        @(negedge clk);
        check_valid(valid_o, 1'b0);
        check_issue(issue_o, model_issue(1'b0, '0, FWD_IDLE, FWD_IDLE, FWD_IDLE));
        for (int i = 0; i < DIR_CYCLES; i++) begin
            inst = random_inst();
            step(1'b0, inst, rand_fwd(inst), rand_fwd(inst), FWD_IDLE);
        end
        drain();
        finish_test("reset and bubbles", e0);
    endtask

    task automatic test_rtype();
        int   e0;
        fwd_t wb;
        e0 = errors;
        for (int i = 1; i < REG_NUM; i++) begin
            wb = '{write: 1'b1, addr: reg_addr_t'(i), data: rand_bits(32)};
            step(1'b0, '0, FWD_IDLE, FWD_IDLE, wb);
        end
        for (int i = 0; i < DIR_CYCLES; i++) begin
            step(1'b1, r_inst(i, rand_addr(), rand_addr(), rand_addr()), FWD_IDLE, FWD_IDLE,
                 FWD_IDLE);
        end
        drain();
        finish_test("r-type", e0);
    endtask

    task automatic test_itype();
        int e0;
        e0 = errors;
        for (int i = 0; i < DIR_CYCLES; i++) begin
            step(1'b1, i_inst(i, rand_addr(), nonzero_addr(), 16'(rand_bits(16))), FWD_IDLE,
                 FWD_IDLE, FWD_IDLE);
        end
        drain();
        finish_test("i-type", e0);
    endtask

    task automatic test_forwarding();
        int        e0;
        reg_addr_t rs;
        reg_addr_t rt;
        fwd_t      ex;
        fwd_t      mem;
        fwd_t      wb;
        e0 = errors;
        for (int i = 0; i < DIR_CYCLES; i++) begin
            rs = nonzero_addr();
            rt = nonzero_addr();
            ex = FWD_IDLE;
            mem = FWD_IDLE;
            wb = FWD_IDLE;
            case (i % 4)
                0: begin
                    ex = '{write: 1'b1, addr: rs, data: rand_bits(32)};
                    mem = '{write: 1'b1, addr: rs, data: rand_bits(32)};
                end
                1: begin
                    ex = '{write: 1'b1, addr: rt, data: rand_bits(32)};
                    mem = '{write: 1'b1, addr: rt, data: rand_bits(32)};
                end
                2: mem = '{write: 1'b1, addr: rt, data: rand_bits(32)};
                default: wb = '{write: 1'b1, addr: rs, data: rand_bits(32)};
            endcase
            step(1'b1, r_inst(i, rs, rt, rand_addr()), ex, mem, wb);
        end
        drain();
        finish_test("forwarding", e0);
    endtask

    task automatic test_zero();
        int    e0;
        word_t inst;
        fwd_t  to_r0;
        e0 = errors;
        for (int i = 0; i < DIR_CYCLES; i++) begin
            to_r0 = '{write: 1'b1, addr: '0, data: rand_bits(32)};
            case (i % 3)
                0: inst = r_inst(i, '0, (i % 2 == 0) ? '0 : rand_addr(), nonzero_addr());
                1: inst = (i % 2 == 0) ? r_inst(i, rand_addr(), rand_addr(), '0)
                                       : i_inst(i, rand_addr(), '0, 16'(rand_bits(16)));
                default: inst = {1'b1, 31'(rand_bits(31))};  // Opcodes 0x20 and up are unknown.
            endcase
            step(1'b1, inst, to_r0, to_r0, to_r0);
        end
        drain();
        finish_test("register zero", e0);
    endtask

    task automatic test_random();
        int    e0;
        word_t inst;
        logic  v;
        e0 = errors;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            inst = random_inst();
            v = (rand_bits(3) != 0);
            step(v, inst, rand_fwd(inst), rand_fwd(inst), rand_fwd(inst));
        end
        drain();
        finish_test("random stream", e0);
    endtask

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog: the run did not finish within %0d cycles.",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        arst_n_i = 1'b0;
        valid_i = 1'b0;
        inst_i = '0;
        ex_fwd_i = FWD_IDLE;
        mem_fwd_i = FWD_IDLE;
        wb_i = FWD_IDLE;
        lfsr_state = 32'h97f538fd;
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        for (int i = 0; i < REG_NUM; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n_i <= 1'b1;
        test_bubbles();
        test_rtype();
        test_itype();
        test_forwarding();
        test_zero();
        test_random();
        $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
common/cpu_pkg.sv
decode/inst_decoder.sv
decode/reg_file.sv
decode/operand_issue.sv
source/decode_stage.sv
verif/decode_stage_props.sv
verif/decode_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
